//--- icache_config.svh
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH
`default_nettype none

// ==================================================
// Line geometry
// ==================================================

// Width of one read beat on the bus
`define ICACHE_BEAT_BITS 256
// Two beats make up one cache line
`define ICACHE_LINE_BEATS 2
// Byte offset bits inside a beat and inside a whole line
`define ICACHE_BEAT_OFFS ($clog2(`ICACHE_BEAT_BITS / 8))
`define ICACHE_LINE_OFFS (`ICACHE_BEAT_OFFS + $clog2(`ICACHE_LINE_BEATS))

// ==================================================
// Bus and miss tracking
// ==================================================

// Transaction id is {slot, beat}, so the slot count is tied to this width
`define ICACHE_TID_BITS 4
`define ICACHE_SLOTS 8
`define ICACHE_SLOT_BITS ($clog2(`ICACHE_SLOTS))
`define ICACHE_VADR_BITS 32
`define ICACHE_PADR_BITS 32
// Core number placed in every request, and the width of that field
`define ICACHE_CORENO 1
`define ICACHE_CID_BITS 6

`default_nettype wire
`endif

//--- icache_pkg.sv
`include "icache_config.svh"
`default_nettype none

package icache_pkg;

	// ==================================================
	// Scalar types
	// ==================================================

	typedef logic [`ICACHE_VADR_BITS-1:0] vadr_t;
	typedef logic [`ICACHE_PADR_BITS-1:0] padr_t;
	typedef logic [`ICACHE_TID_BITS-1:0] tid_t;
	typedef logic [`ICACHE_SLOT_BITS-1:0] slot_t;
	typedef logic [`ICACHE_CID_BITS-1:0] coreno_t;
	typedef logic [`ICACHE_BEAT_BITS-1:0] beat_t;

	// Tag arrays indexed by slot, shared between request and ack sides
	typedef vadr_t [`ICACHE_SLOTS-1:0] slot_vtags_t;
	typedef padr_t [`ICACHE_SLOTS-1:0] slot_ptags_t;

	// A full line; beat 0 holds the lower half of the line address range
	typedef beat_t [`ICACHE_LINE_BEATS-1:0] icache_line_t;

	// Response kind; IRQ responses carry an interrupt record, not data
	typedef enum logic [1:0] {
		OKAY = 2'd0,
		ERR  = 2'd1,
		IRQ  = 2'd2
	} resp_kind_e;

	// ==================================================
	// Bus records
	// ==================================================

	// Read request for one beat
	// The address is the line address with the beat index filled in
	typedef struct packed {
		logic    cyc;
		tid_t    tid;
		coreno_t cid;
		padr_t   padr;
	} bus_req_t;

	// Interrupt record as delivered by the bus, one 32-bit word
	typedef struct packed {
		logic [31-`ICACHE_CID_BITS-12:0] rsvd;
		coreno_t    src_core;
		logic [7:0] cause;
		logic [3:0] level;
	} irq_rec_t;

	// Interrupt view of the payload, the record sits in the low word
	typedef struct packed {
		logic [`ICACHE_BEAT_BITS-$bits(irq_rec_t)-1:0] pad;
		irq_rec_t rec;
	} irq_view_t;

	// The same payload word read either as a data beat or as an interrupt
	typedef union packed {
		beat_t     data;
		irq_view_t irq;
	} bus_payload_u;

	// Response for one beat, or an interrupt notification
	typedef struct packed {
		logic         ack;
		resp_kind_e   kind;
		tid_t         tid;
		bus_payload_u dat;
	} bus_resp_t;

endpackage

`default_nettype wire

//--- icache_req_gen.sv
`include "icache_config.svh"
`default_nettype none

module icache_req_gen (
	input  wire clk,
	input  wire rst,
	input  wire hit,
	input  wire tlb_v,
	input  wire miss_v,
	input  wire icache_pkg::vadr_t miss_vadr,
	input  wire icache_pkg::padr_t miss_padr,
	input  wire ftam_full,
	input  wire wr_ic,
	input  wire icache_pkg::slot_t fill_slot,
	output icache_pkg::bus_req_t wbm_req,
	output icache_pkg::slot_vtags_t slot_vtags,
	output icache_pkg::slot_ptags_t slot_ptags
);
	import icache_pkg::*;

	// Which beat is presented in wbm_req while cyc is high
	typedef enum logic {
		ISS_B0 = 1'b0,
		ISS_B1 = 1'b1
	} iss_st_e;

	logic [`ICACHE_SLOTS-1:0] busy;
	logic [`ICACHE_SLOTS-1:0] dup_hit;
	logic any_free;
	slot_t free_slot;
	iss_st_e iss_st;
	logic last_out;
	logic iss_busy;
	logic accept;

	// Beat address inside the line of a, with the byte offset cleared
	function automatic padr_t beat_adr(input padr_t a, input logic b);
		return {a[`ICACHE_PADR_BITS-1:`ICACHE_LINE_OFFS], b, {`ICACHE_BEAT_OFFS{1'b0}}};
	endfunction

	// ==================================================
	// Miss acceptance
	// ==================================================

	// Lowest numbered free slot
	// Scanning downward lets the last match win
	always_comb begin
		any_free = 1'b0;
		free_slot = '0;
		for (int i = `ICACHE_SLOTS - 1; i >= 0; i--) begin
			if (!busy[i]) begin
				any_free = 1'b1;
				free_slot = slot_t'(i);
			end
		end
	end

	// A line already in flight in any busy slot must not be requested twice
	always_comb begin
		for (int i = 0; i < `ICACHE_SLOTS; i++) begin
			dup_hit[i] = busy[i] &&
				slot_ptags[i][`ICACHE_PADR_BITS-1:`ICACHE_LINE_OFFS] ==
				miss_padr[`ICACHE_PADR_BITS-1:`ICACHE_LINE_OFFS];
		end
	end

	// The last beat leaves the request port this cycle
	assign last_out = wbm_req.cyc && iss_st == ISS_B1 && !ftam_full;

	// The sequencer counts as free once its final beat is going out,
	// so a new miss can follow back to back without cyc dropping
	assign iss_busy = wbm_req.cyc && !last_out;

	assign accept = miss_v && tlb_v && !hit && !iss_busy && any_free && !(|dup_hit);

	// ==================================================
	// Slot state
	// ==================================================

	// A slot stays busy until its line has been written into the cache
	// The slot being freed is busy this cycle, so it is never the one picked
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= '0;
		end
		else begin
			if (wr_ic)
				busy[fill_slot] <= 1'b0;
			if (accept)
				busy[free_slot] <= 1'b1;
		end
	end

	// Tags are kept for the ack side, which copies them out with the line
	always_ff @(posedge clk) begin
		if (accept) begin
			slot_vtags[free_slot] <= miss_vadr;
			slot_ptags[free_slot] <= miss_padr;
		end
	end

	// ==================================================
	// Issue sequencer
	// ==================================================

	// Beat 0 is loaded on accept, beat 1 once beat 0 is taken by the bus
	// While ftam_full is high nothing in wbm_req changes
	always_ff @(posedge clk) begin
		if (rst) begin
			wbm_req.cyc <= 1'b0;
			iss_st <= ISS_B0;
		end
		else if (accept) begin
			wbm_req.cyc <= 1'b1;
			wbm_req.tid <= {free_slot, 1'b0};
			wbm_req.cid <= coreno_t'(`ICACHE_CORENO);
			wbm_req.padr <= beat_adr(miss_padr, 1'b0);
			iss_st <= ISS_B0;
		end
		else if (wbm_req.cyc && !ftam_full) begin
			if (iss_st == ISS_B0) begin
				// Same slot, second half of the line
				wbm_req.tid[0] <= 1'b1;
				wbm_req.padr <= beat_adr(wbm_req.padr, 1'b1);
				iss_st <= ISS_B1;
			end
			else begin
				// Both beats are out and no miss is waiting
				wbm_req.cyc <= 1'b0;
				iss_st <= ISS_B0;
			end
		end
	end

endmodule

`default_nettype wire

//--- icache_ack_proc.sv
`include "icache_config.svh"
`default_nettype none

module icache_ack_proc #(
	parameter int WAYS = 4,
	localparam int WAY_BITS = (WAYS > 1) ? $clog2(WAYS) : 1
) (
	input  wire clk,
	input  wire rst,
	input  wire icache_pkg::bus_resp_t wbm_resp,
	input  wire icache_pkg::slot_vtags_t slot_vtags,
	input  wire icache_pkg::slot_ptags_t slot_ptags,
	output logic wr_ic,
	output icache_pkg::slot_t fill_slot,
	output icache_pkg::icache_line_t line_o,
	output icache_pkg::vadr_t fill_vadr,
	output icache_pkg::padr_t fill_padr,
	output logic [WAY_BITS-1:0] way,
	output logic irq_v,
	output icache_pkg::irq_rec_t irq_o
);
	import icache_pkg::*;

	slot_t resp_slot;
	logic resp_beat;
	logic is_irq;
	logic is_beat;
	logic line_done;
	icache_line_t line_nxt;
	logic [`ICACHE_SLOTS-1:0][`ICACHE_LINE_BEATS-1:0] arrived;
	beat_t beat_mem [`ICACHE_SLOTS][`ICACHE_LINE_BEATS];

	// ==================================================
	// Response decode
	// ==================================================

	// Upper id bits select the slot, the low bit the half of the line
	assign resp_slot = wbm_resp.tid[`ICACHE_TID_BITS-1:1];
	assign resp_beat = wbm_resp.tid[0];

	// Interrupts are split off here and never reach the slot buffers
	assign is_irq = wbm_resp.ack && wbm_resp.kind == IRQ;

	// There is no retry path, so an ERR beat is stored like an OKAY one
	// and the slot still drains
	assign is_beat = wbm_resp.ack && wbm_resp.kind != IRQ;

	// The other half already arrived, so this beat completes the line
	assign line_done = is_beat && arrived[resp_slot][~resp_beat];

	// Incoming beat is bypassed into its half, the other half comes from the buffer
	always_comb begin
		for (int b = 0; b < `ICACHE_LINE_BEATS; b++) begin
			if (b == int'(resp_beat))
				line_nxt[b] = wbm_resp.dat.data;
			else
				line_nxt[b] = beat_mem[resp_slot][b];
		end
	end

	// ==================================================
	// Beat collection
	// ==================================================

	// Buffer holds beats until the partner beat of the slot shows up
	always_ff @(posedge clk) begin
		if (is_beat)
			beat_mem[resp_slot][resp_beat] <= wbm_resp.dat.data;
	end

	// Arrival bits per slot and beat
	// Cleared as the line is handed off so the slot can be reused
	always_ff @(posedge clk) begin
		if (rst) begin
			arrived <= '0;
		end
		else if (is_beat) begin
			if (line_done)
				arrived[resp_slot] <= '0;
			else
				arrived[resp_slot][resp_beat] <= 1'b1;
		end
	end

	// ==================================================
	// Cache write
	// ==================================================

	// wr_ic is high for one cycle per completed line
	// way steps round robin once each write has gone out
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ic <= 1'b0;
			way <= '0;
		end
		else begin
			wr_ic <= line_done;
			if (wr_ic)
				way <= (way == WAY_BITS'(WAYS - 1)) ? '0 : way + 1'b1;
		end
	end

	// Line and tags are captured with the completing beat
	// The slot is still busy in the generator, so its tags are valid here
	always_ff @(posedge clk) begin
		if (line_done) begin
			fill_slot <= resp_slot;
			line_o <= line_nxt;
			fill_vadr <= slot_vtags[resp_slot];
			fill_padr <= slot_ptags[resp_slot];
		end
	end

	// ==================================================
	// Interrupt path
	// ==================================================

	always_ff @(posedge clk) begin
		if (rst)
			irq_v <= 1'b0;
		else
			irq_v <= is_irq;
	end

	// Same payload word, read through its interrupt view
	always_ff @(posedge clk) begin
		if (is_irq)
			irq_o <= wbm_resp.dat.irq.rec;
	end

endmodule

`default_nettype wire

//--- icache_fill_ctrl.sv
`default_nettype none

module icache_fill_ctrl #(
	parameter int WAYS = 4,
	localparam int WAY_BITS = (WAYS > 1) ? $clog2(WAYS) : 1
) (
	input  wire clk,
	input  wire rst,
	input  wire ftam_full,
	input  wire hit,
	input  wire tlb_v,
	input  wire miss_v,
	input  wire icache_pkg::vadr_t miss_vadr,
	input  wire icache_pkg::padr_t miss_padr,
	input  wire icache_pkg::bus_resp_t wbm_resp,
	output icache_pkg::bus_req_t wbm_req,
	output logic wr_ic,
	output logic [WAY_BITS-1:0] way,
	output icache_pkg::icache_line_t line_o,
	output icache_pkg::vadr_t fill_vadr,
	output icache_pkg::padr_t fill_padr,
	output logic irq_v,
	output icache_pkg::irq_rec_t irq_o
);
	import icache_pkg::*;

	// Tags of every outstanding miss, looked up by the ack side
	slot_vtags_t slot_vtags;
	slot_ptags_t slot_ptags;
	// Slot whose line is being written, freed in the generator after wr_ic
	slot_t fill_slot;

	// Accepts misses and issues the two read beats of each line
	icache_req_gen u_req_gen (
		.clk(clk),
		.rst(rst),
		.hit(hit),
		.tlb_v(tlb_v),
		.miss_v(miss_v),
		.miss_vadr(miss_vadr),
		.miss_padr(miss_padr),
		.ftam_full(ftam_full),
		.wr_ic(wr_ic),
		.fill_slot(fill_slot),
		.wbm_req(wbm_req),
		.slot_vtags(slot_vtags),
		.slot_ptags(slot_ptags)
	);

	// Collects responses, passes interrupts on, writes finished lines
	icache_ack_proc #(
		.WAYS(WAYS)
	) u_ack_proc (
		.clk(clk),
		.rst(rst),
		.wbm_resp(wbm_resp),
		.slot_vtags(slot_vtags),
		.slot_ptags(slot_ptags),
		.wr_ic(wr_ic),
		.fill_slot(fill_slot),
		.line_o(line_o),
		.fill_vadr(fill_vadr),
		.fill_padr(fill_padr),
		.way(way),
		.irq_v(irq_v),
		.irq_o(irq_o)
	);

endmodule

`default_nettype wire

//--- icache_fill_props.sv
`default_nettype none

module icache_fill_props #(
	parameter int WAYS = 4,
	localparam int WAY_BITS = (WAYS > 1) ? $clog2(WAYS) : 1
) (
	input wire clk,
	input wire rst,
	input wire ftam_full,
	input wire icache_pkg::bus_req_t wbm_req,
	input wire wr_ic,
	input wire irq_v,
	input wire [WAY_BITS-1:0] way
);
	timeunit 1ns;
	timeprecision 100ps;

	// A request held back by a full FIFO stays put until the bus takes it
	req_stable: assert property (@(posedge clk) disable iff (rst)
		wbm_req.cyc && ftam_full |=> $stable(wbm_req))
		else $error("wbm_req changed while cyc and ftam_full were high");

	// Each completed line gives one write strobe
	wr_ic_pulse: assert property (@(posedge clk) disable iff (rst)
		wr_ic |=> !wr_ic)
		else $error("wr_ic high for more than one cycle");

	irq_v_pulse: assert property (@(posedge clk) disable iff (rst)
		irq_v |=> !irq_v)
		else $error("irq_v high for more than one cycle");

	// After each write the victim way moves one on and wraps below WAYS
	way_step: assert property (@(posedge clk) disable iff (rst)
		wr_ic |=> int'(way) == (int'($past(way)) + 1) % WAYS)
		else $error("victim way %0d did not step after a write", way);

endmodule

bind icache_fill_ctrl icache_fill_props #(.WAYS(WAYS)) u_props (
	.clk(clk), .rst(rst), .ftam_full(ftam_full), .wbm_req(wbm_req),
	.wr_ic(wr_ic), .irq_v(irq_v), .way(way)
);

`default_nettype wire

//--- tb_icache_fill.sv
`include "icache_config.svh"
`default_nettype none

module tb_icache_fill;
	timeunit 1ns;
	timeprecision 100ps;
	import icache_pkg::*;

	localparam int WAYS = 4;
	localparam int CLK_PERIOD = 40;
	localparam int NUM_MISSES = 60;

	// One miss as the core presents it
	typedef struct packed {
		vadr_t vadr;
		padr_t padr;
	} miss_t;

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic ftam_full = 1'b0;
	logic hit = 1'b0;
	logic tlb_v = 1'b0;
	logic miss_v = 1'b0;
	vadr_t miss_vadr = '0;
	padr_t miss_padr = '0;
	bus_resp_t wbm_resp = '0;
	bus_req_t wbm_req;
	logic wr_ic;
	logic [$clog2(WAYS)-1:0] way;
	icache_line_t line_o;
	vadr_t fill_vadr;
	padr_t fill_padr;
	logic irq_v;
	irq_rec_t irq_o;

	// Reference model of the request side, the slots and the fill order
	logic [31:0] rng = 32'd99733;
	bus_req_t m_req;
	logic m_st;
	logic [`ICACHE_SLOTS-1:0] m_busy;
	vadr_t m_vtag [`ICACHE_SLOTS];
	padr_t m_ptag [`ICACHE_SLOTS];
	logic [1:0] m_arr [`ICACHE_SLOTS];
	logic accept;
	slot_t acc_slot;
	logic exp_fill;
	logic exp_irq;
	slot_t exp_slot;
	irq_rec_t exp_rec;
	int way_cnt;
	// Misses the core still retries, and beats the bus has yet to answer
	miss_t pend_q[$];
	bus_req_t out_q[$];
	int miss_gen = 0;
	int lines_acc = 0;
	int beats_out = 0;
	int fills = 0;
	int irq_sent = 0;
	int irq_seen = 0;
	int req_errs = 0;
	int fill_errs = 0;
	int irq_errs = 0;
	int end_errs = 0;
	logic drained = 1'b0;

	icache_fill_ctrl #(.WAYS(WAYS)) u_dut (.*);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic logic [31:0] rand32();
		rng = xorshift32(rng);
		return rng;
	endfunction

	// Address of beat b in the line holding a, byte offset cleared
	function automatic padr_t beat_addr(input padr_t a, input logic b);
		padr_t l;
		l = (a >> `ICACHE_LINE_OFFS) << `ICACHE_LINE_OFFS;
		return l | (padr_t'(b) << `ICACHE_BEAT_OFFS);
	endfunction

	// Bus data of a beat is a chain of xorshift words seeded by its address
	function automatic beat_t beat_data(input padr_t a);
		beat_t d;
		logic [31:0] w;
		int i;
		w = a;
		for (i = 0; i < `ICACHE_BEAT_BITS / 32; i++) begin
			w = xorshift32(w);
			d[i*32 +: 32] = w;
		end
		return d;
	endfunction

	function automatic int error_total();
		return req_errs + fill_errs + irq_errs + end_errs;
	endfunction

	// ==================================================
	// Model steps, run in order at every rising edge
	// ==================================================

	task automatic reset_model();
		int i;
		m_req = '0;
		m_st = 1'b0;
		m_busy = '0;
		for (i = 0; i < `ICACHE_SLOTS; i++)
			m_arr[i] = '0;
		exp_fill = 1'b0;
		exp_irq = 1'b0;
		way_cnt = 0;
	endtask

	// Acceptance rule, evaluated on the inputs and slots the DUT sees at this edge
	task automatic decide_accept();
		logic iss_busy;
		logic found;
		logic dup;
		int i;
		iss_busy = m_req.cyc && !(m_st && !ftam_full);
		found = 1'b0;
		dup = 1'b0;
		acc_slot = '0;
		for (i = 0; i < `ICACHE_SLOTS; i++) begin
			if (!found && !m_busy[i]) begin
				found = 1'b1;
				acc_slot = slot_t'(i);
			end
			if (m_busy[i] && beat_addr(m_ptag[i], 1'b0) == beat_addr(miss_padr, 1'b0))
				dup = 1'b1;
		end
		accept = miss_v && tlb_v && !hit && !iss_busy && found && !dup;
	endtask

	task automatic check_request();
		if (wbm_req.cyc !== m_req.cyc) begin
			$display("FAILED wbm_req.cyc: got %h expected %h", wbm_req.cyc, m_req.cyc);
			req_errs++;
		end
		else if (m_req.cyc && wbm_req !== m_req) begin
			$display("FAILED wbm_req: got %h expected %h", wbm_req, m_req);
			req_errs++;
		end
		// The bus takes whatever beat the DUT presents when the FIFO has room
		if (wbm_req.cyc === 1'b1 && !ftam_full) begin
			foreach (out_q[i]) begin
				if (out_q[i].tid == wbm_req.tid) begin
					$display("transaction id %h reused while a beat with it is outstanding",
						wbm_req.tid);
					req_errs++;
				end
			end
			out_q.push_back(wbm_req);
			beats_out++;
		end
	endtask

	task automatic check_fill_irq();
		icache_line_t exp_line;
		padr_t p;
		int i;
		// Count the writes and interrupts the DUT actually delivers
		if (wr_ic)
			fills++;
		if (irq_v)
			irq_seen++;
		if (exp_fill) begin
			p = m_ptag[exp_slot];
			exp_line = {beat_data(beat_addr(p, 1'b1)), beat_data(beat_addr(p, 1'b0))};
			if (!wr_ic) begin
				$display("no cache write after the last beat of slot %0d", exp_slot);
				fill_errs++;
			end
			if (line_o !== exp_line) begin
				$display("FAILED line_o: got %h expected %h", line_o, exp_line);
				fill_errs++;
			end
			if (fill_vadr !== m_vtag[exp_slot]) begin
				$display("FAILED fill_vadr: got %h expected %h", fill_vadr, m_vtag[exp_slot]);
				fill_errs++;
			end
			if (fill_padr !== p) begin
				$display("FAILED fill_padr: got %h expected %h", fill_padr, p);
				fill_errs++;
			end
			if (way !== way_cnt) begin
				$display("FAILED way: got %h expected %h", way, way_cnt);
				fill_errs++;
			end
			way_cnt = (way_cnt + 1) % WAYS;
			m_busy[exp_slot] = 1'b0;
			// Every retry of this line is now satisfied
			for (i = pend_q.size() - 1; i >= 0; i--)
				if (beat_addr(pend_q[i].padr, 1'b0) == beat_addr(p, 1'b0))
					pend_q.delete(i);
		end
		else if (wr_ic) begin
			$display("cache write with no completed line behind it");
			fill_errs++;
		end
		if (exp_irq) begin
			if (!irq_v || irq_o !== exp_rec) begin
				$display("FAILED irq_o: got %h (irq_v %h) expected %h", irq_o, irq_v, exp_rec);
				irq_errs++;
			end
		end
		else if (irq_v) begin
			$display("interrupt output raised with no interrupt response");
			irq_errs++;
		end
	endtask

	task automatic advance_model();
		if (accept) begin
			m_busy[acc_slot] = 1'b1;
			m_vtag[acc_slot] = miss_vadr;
			m_ptag[acc_slot] = miss_padr;
			m_req.cyc = 1'b1;
			m_req.tid = {acc_slot, 1'b0};
			m_req.cid = coreno_t'(`ICACHE_CORENO);
			m_req.padr = beat_addr(miss_padr, 1'b0);
			m_st = 1'b0;
			lines_acc++;
		end
		else if (m_req.cyc && !ftam_full) begin
			if (!m_st) begin
				m_req.tid[0] = 1'b1;
				m_req.padr = beat_addr(m_req.padr, 1'b1);
				m_st = 1'b1;
			end
			else begin
				m_req.cyc = 1'b0;
				m_st = 1'b0;
			end
		end
	endtask

	// The response seen at this edge decides what the outputs show at the next
	task automatic track_response();
		slot_t s;
		logic b;
		exp_fill = 1'b0;
		exp_irq = 1'b0;
		s = wbm_resp.tid[`ICACHE_TID_BITS-1:1];
		b = wbm_resp.tid[0];
		if (wbm_resp.ack && wbm_resp.kind == IRQ) begin
			exp_irq = 1'b1;
			exp_rec = wbm_resp.dat.irq.rec;
		end
		else if (wbm_resp.ack) begin
			if (m_arr[s][!b]) begin
				exp_fill = 1'b1;
				exp_slot = s;
				m_arr[s] = '0;
			end
			else begin
				m_arr[s][b] = 1'b1;
			end
		end
	endtask

	task automatic drive_inputs();
		logic [31:0] r;
		int idx;
		miss_t m;
		bus_req_t beat;
		bus_resp_t resp;
		r = rand32();
		// New misses come from twelve lines, so repeats and in-flight hits are common
		if (miss_gen < NUM_MISSES && pend_q.size() < 10 && r[1:0] == 2'd0) begin
			m.padr = 32'h8000_0000 | (padr_t'(rand32() % 12) << `ICACHE_LINE_OFFS) |
				padr_t'(rand32() % (1 << `ICACHE_LINE_OFFS));
			m.vadr = rand32();
			pend_q.push_back(m);
			miss_gen++;
		end
		if (pend_q.size() > 0) begin
			m = pend_q[rand32() % pend_q.size()];
			miss_v <= 1'b1;
			miss_vadr <= m.vadr;
			miss_padr <= m.padr;
		end
		else begin
			miss_v <= 1'b0;
		end
		hit <= (r[4:2] == 3'd0);
		tlb_v <= (r[7:5] != 3'd0);
		ftam_full <= (r[9:8] == 2'd0);
		// Bus answers outstanding beats in random order, never two cycles in a row
		resp = '0;
		if (!wbm_resp.ack && out_q.size() > 0 && r[11:10] != 2'd0) begin
			idx = rand32() % out_q.size();
			beat = out_q[idx];
			out_q.delete(idx);
			resp.ack = 1'b1;
			resp.kind = OKAY;
			resp.tid = beat.tid;
			resp.dat.data = beat_data(beat.padr);
		end
		else if (!wbm_resp.ack && miss_gen < NUM_MISSES && r[14:12] == 3'd0) begin
			resp.ack = 1'b1;
			resp.kind = IRQ;
			resp.tid = tid_t'(rand32());
			resp.dat.irq.pad = {7{rand32()}};
			resp.dat.irq.rec = irq_rec_t'(rand32());
			irq_sent++;
		end
		wbm_resp <= resp;
		drained = miss_gen == NUM_MISSES && pend_q.size() == 0 && out_q.size() == 0 &&
			!m_req.cyc && m_busy == '0;
	endtask

	// ==================================================
	// Clock, model process, run control
	// ==================================================

	initial begin
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		if (rst) begin
			reset_model();
		end
		else begin
			decide_accept();
			check_request();
			check_fill_irq();
			advance_model();
			track_response();
			drive_inputs();
		end
	end

	initial begin
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		while (!drained)
			@(posedge clk);
		repeat (4) @(posedge clk);
		if (beats_out != 2 * lines_acc || fills != lines_acc) begin
			$display("%0d beats and %0d fills issued for %0d accepted lines",
				beats_out, fills, lines_acc);
			end_errs++;
		end
		if (irq_seen != irq_sent) begin
			$display("%0d interrupts injected but %0d delivered", irq_sent, irq_seen);
			end_errs++;
		end
		$display("errors: request %0d, fill %0d, irq %0d, end of run %0d (lines %0d, irqs %0d)",
			req_errs, fill_errs, irq_errs, end_errs, lines_acc, irq_sent);
		if (error_total() == 0) begin
			$display("STATUS: PASS");
		end
		else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	// Generous bound of 200 cycles per miss
	initial begin
		#(NUM_MISSES * 200 * CLK_PERIOD);
		$display("timeout: the misses did not drain, %0d of %0d lines filled", fills, lines_acc);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
+incdir+.
icache_pkg.sv
icache_req_gen.sv
icache_ack_proc.sv
icache_fill_ctrl.sv
icache_fill_props.sv
tb_icache_fill.sv
